//--- sources.f
source/fetch_pkg.sv
source/fetch_redirect.sv
source/fetch_control.sv
source/fetch_buffer.sv
source/fetch_unit.sv
verif/fetch_unit_chk.sv
verif/fetch_unit_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module fetch_unit_tb
output=$(./obj_dir/Vfetch_unit_tb)
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
  exit 0
else
  exit 1
fi

//--- verif/fetch_unit_tb.sv
`default_nettype none

module fetch_unit_tb import fetch_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int period = 40;
  localparam int pair_wait = 40; // cycles allowed for one pair or request.
  // cycle budgets of the tests, in run order.
  localparam int budget_cycles = 60 + 5 * 120 + 2 * 120 + 100 + 200;

  logic         clock;
  logic         reset;
  redirect_in_t redirect_in;
  logic         clear;
  logic         halt;
  imem_rsp_t    imem_rsp;
  imem_req_t    imem_req;
  fetch_pair_t  pair;
  int           errors;

  logic            mem_pending;
  int              mem_wait;
  logic [xlen-1:0] mem_addr;

  fetch_unit dut_i (
    .clock       (clock),
    .reset       (reset),
    .redirect_in (redirect_in),
    .clear       (clear),
    .halt        (halt),
    .imem_rsp    (imem_rsp),
    .imem_req    (imem_req),
    .pair        (pair)
  );

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // memory model
  // ~~~~~~~~~~~~~~~~~~~~
  // every word holds its own address, and a response carries the whole aligned line.

  always @(posedge clock) begin
    imem_rsp.ready <= 1'b0;
    if (!reset) begin
      mem_pending = 1'b0;
    end else begin
      if (mem_pending) begin
        mem_wait = mem_wait - 1;
        if (mem_wait == 0) begin
          imem_rsp.ready <= 1'b1;
          imem_rsp.rdata <= {mem_addr + 32'd4, mem_addr};
          mem_pending = 1'b0;
        end
      end
      if (imem_req.valid) begin
        mem_pending = 1'b1;
        mem_wait = int'($urandom_range(3, 1));
        mem_addr = {imem_req.addr[xlen-1:3], 3'b000};
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", test, what, expected, actual);
    end
  endtask

  task automatic apply_reset();
    @(posedge clock);
    reset <= 1'b0;
    clear <= 1'b1;
    halt <= 1'b0;
    redirect_in <= '0;
    repeat (3) @(posedge clock);
    reset <= 1'b1;
  endtask

  task automatic start_fetch();
    @(posedge clock);
    clear <= 1'b0;
  endtask

  task automatic drive_redirect(input redirect_in_t r);
    @(posedge clock);
    redirect_in <= r;
    @(posedge clock);
    redirect_in <= '0;
  endtask

  // waits for a pair that decode takes at the next edge.
  task automatic wait_pair(input string test, output bit found);
    int n;
    found = 1'b0;
    for (n = 0; n < pair_wait; n++) begin
      @(negedge clock);
      if (pair.ready1 && !halt) begin
        found = 1'b1;
        break;
      end
    end
    if (!found) begin
      errors++;
      $display("%s: no instruction pair arrived within %0d cycles", test, pair_wait);
    end
  endtask

  // the first request after a redirect carries spec.
  task automatic check_request(input string test, input logic [31:0] addr, input logic fence,
                               input logic spec);
    int n;
    bit found;
    found = 1'b0;
    for (n = 0; n < pair_wait; n++) begin
      @(negedge clock);
      if (imem_req.valid) begin
        found = 1'b1;
        break;
      end
    end
    if (!found) begin
      errors++;
      $display("%s: no memory request was issued within %0d cycles", test, pair_wait);
    end else begin
      check_value(test, "request addr", {addr[31:2], 2'b00}, imem_req.addr);
      check_value(test, "request fence", 32'(fence), 32'(imem_req.fence));
      check_value(test, "request spec", 32'(spec), 32'(imem_req.spec));
    end
  endtask

  // pairs follow line by line from start; an odd start skips the lower slot once.
  task automatic expect_pairs(input string test, input logic [31:0] start, input int count);
    logic [31:0] base;
    bit          found;
    int          i;
    base = {start[31:3], 3'b000};
    for (i = 0; i < count; i++) begin
      wait_pair(test, found);
      if (!found) return;
      check_value(test, "pc0", base, pair.pc0);
      check_value(test, "pc1", base + 32'd4, pair.pc1);
      check_value(test, "instr0", base, pair.instr0);
      check_value(test, "instr1", base + 32'd4, pair.instr1);
      check_value(test, "ready0", (i == 0 && start[2]) ? 32'd0 : 32'd1, 32'(pair.ready0));
      check_value(test, "ready1", 32'd1, 32'(pair.ready1));
      base = base + 32'd8;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // tests
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic test_sequential();
    apply_reset();
    start_fetch();
    expect_pairs("sequential", 32'h0, 8);
  endtask

  task automatic test_priority();
    redirect_in_t r;
    logic [31:0]  target [5];
    int           k;
    target = '{32'h100, 32'h200, 32'h300, 32'h400, 32'h500};
    for (k = 0; k < 5; k++) begin
      apply_reset();
      start_fetch();
      expect_pairs("priority", 32'h0, 2);
      r = '0;
      r.mtvec = target[0];
      r.mepc = target[1];
      r.miss_addr = target[2];
      r.fence_npc = target[3];
      r.taddr = target[4];
      r.trap = (k <= 0); // source k and every lower one are raised together.
      r.mret = (k <= 1);
      r.miss = (k <= 2);
      r.fence = (k <= 3);
      r.taken = 1'b1;
      drive_redirect(r);
      check_request("priority", target[k], k == 3, 1'b1);
      expect_pairs("priority", target[k], 3);
    end
  endtask

  task automatic test_cancel(input logic fence, input logic [31:0] target);
    redirect_in_t r;
    apply_reset();
    start_fetch();
    expect_pairs("cancel", 32'h0, 1);
    // the request for line 8 left with the response for line 0, so line 16 comes next.
    check_request("cancel", 32'h10, 1'b0, 1'b0);
    // the response to that request cannot come before the next edge plus one.
    r = '0;
    r.fence = fence;
    r.fence_npc = target;
    r.taken = ~fence;
    r.taddr = target;
    drive_redirect(r);
    check_request("cancel", target, fence, 1'b1);
    expect_pairs("cancel", target, 4);
  endtask

  task automatic test_odd_half();
    redirect_in_t r;
    apply_reset();
    start_fetch();
    expect_pairs("odd half", 32'h0, 1);
    r = '0;
    r.taken = 1'b1;
    r.taddr = 32'h604;
    drive_redirect(r);
    check_request("odd half", 32'h604, 1'b0, 1'b1);
    expect_pairs("odd half", 32'h604, 3);
  endtask

  task automatic test_halt();
    int i;
    apply_reset();
    @(posedge clock);
    halt <= 1'b1;
    clear <= 1'b0;
    repeat (40) @(negedge clock); // long enough for the buffer to fill.
    // the first line stays at the head while decode is held.
    for (i = 0; i < 10; i++) begin
      @(negedge clock);
      check_value("halt", "held pair pc0", 32'h0, pair.pc0);
      check_value("halt", "held pair instr1", 32'h4, pair.instr1);
      check_value("halt", "held pair ready1", 32'd1, 32'(pair.ready1));
      check_value("halt", "request while full", 32'd0, 32'(imem_req.valid));
    end
    @(posedge clock);
    halt <= 1'b0;
    expect_pairs("halt", 32'h0, 10);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // run
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    #(20 * budget_cycles * period);
    errors++;
    $display("watchdog expired: the tests did not finish in time, errors: %0d", errors);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    errors = 0;
    void'($urandom(32'hd346661e));
    reset = 1'b0;
    clear = 1'b1;
    halt = 1'b0;
    redirect_in = '0;
    imem_rsp = '0;
    mem_pending = 1'b0;
    mem_wait = 0;
    mem_addr = '0;

    test_sequential();
    test_priority();
    test_cancel(1'b0, 32'h700);
    test_cancel(1'b1, 32'h800); // a fence waits in the invalidate state.
    test_odd_half();
    test_halt();

    $display("tests done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/fetch_unit_chk.sv
`default_nettype none

module fetch_unit_chk (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic rsp_ready,
  input logic redirect_spec,
  input logic line_push,
  input logic at_depth   // every buffer entry is occupied.
);

  timeunit 1ns;
  timeprecision 1ps;

  logic outstanding; // a request still waits for its response.
  logic cancelled;   // the outstanding request was overtaken by a redirect.

  always_ff @(posedge clock) begin
    if (!reset) begin
      outstanding <= 1'b0;
      cancelled <= 1'b0;
    end else begin
      if (req_valid) begin
        outstanding <= 1'b1;
      end else if (rsp_ready) begin
        outstanding <= 1'b0;
      end
      if (rsp_ready) begin
        cancelled <= 1'b0; // the response of the cancelled request has ended it.
      end else if (redirect_spec && outstanding) begin
        cancelled <= 1'b1;
      end
    end
  end

  a_no_request_in_reset : assert property (@(posedge clock) !reset |-> !req_valid)
    else $error("memory request issued while reset is active");

  a_no_push_when_cancelled : assert property (
    @(posedge clock) disable iff (!reset) (cancelled && rsp_ready) |-> !line_push)
    else $error("cancelled response pushed into the buffer");

  a_no_push_when_full : assert property (
    @(posedge clock) disable iff (!reset) at_depth |-> !line_push)
    else $error("line pushed into a buffer with no free entry");

endmodule

bind fetch_unit fetch_unit_chk chk_i (
  .clock         (clock),
  .reset         (reset),
  .req_valid     (imem_req.valid),
  .rsp_ready     (imem_rsp.ready),
  .redirect_spec (redirect.spec),
  .line_push     (line_push),
  // the count msb is set only at buffer_depth entries.
  .at_depth      (buffer_i.count[fetch_pkg::buffer_ptr_bits])
);

`default_nettype wire

//--- source/fetch_unit.sv
`default_nettype none

module fetch_unit import fetch_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  redirect_in_t redirect_in,
  input  logic         clear,
  input  logic         halt,
  input  imem_rsp_t    imem_rsp,
  output imem_req_t    imem_req,
  output fetch_pair_t  pair
);

  redirect_t   redirect;
  logic        full;
  logic        line_push;
  fetch_line_t line;

  fetch_redirect redirect_i (
    .redirect_in (redirect_in),
    .redirect    (redirect)
  );

  // pc, request state machine and memory port.
  fetch_control control_i (
    .clock     (clock),
    .reset     (reset),
    .clear     (clear),
    .redirect  (redirect),
    .full      (full),
    .imem_rsp  (imem_rsp),
    .imem_req  (imem_req),
    .line_push (line_push),
    .line      (line)
  );

  fetch_buffer buffer_i (
    .clock     (clock),
    .reset     (reset),
    .redirect  (redirect),
    .halt      (halt),
    .line_push (line_push),
    .line      (line),
    .full      (full),
    .pair      (pair)
  );

endmodule

`default_nettype wire

//--- source/fetch_buffer.sv
`default_nettype none

module fetch_buffer import fetch_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  redirect_t   redirect,
  input  logic        halt,
  input  logic        line_push,
  input  fetch_line_t line,
  output logic        full,
  output fetch_pair_t pair
);

  fetch_line_t                queue [buffer_depth];
  logic [buffer_ptr_bits-1:0] head;
  logic [buffer_ptr_bits-1:0] tail;
  logic [buffer_ptr_bits:0]   count;
  logic                       push;
  logic                       pop;
  logic                       head_valid;
  fetch_line_t                head_line;

  assign head_valid = (count != '0);
  assign push = line_push & ~redirect.spec; // a redirect drops the arriving line too.
  assign pop = head_valid & ~halt;
  assign full = (count >= (buffer_ptr_bits + 1)'(full_level));

  // ~~~~~~~~~~~~~~~~~~~~
  // queue storage
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (push) begin
      queue[tail] <= line;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      head <= '0;
      tail <= '0;
      count <= '0;
    end else if (redirect.spec) begin
      // the whole stream is stale after a redirect.
      head <= '0;
      tail <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // head pair
  // ~~~~~~~~~~~~~~~~~~~~

  assign head_line = queue[head];

  always_comb begin
    pair.pc0 = {head_line.pc[xlen-1:3], 1'b0, head_line.pc[1:0]};
    pair.pc1 = pair.pc0 + xlen'(instr_bytes);
    pair.instr0 = head_line.rdata[xlen-1:0];
    pair.instr1 = head_line.rdata[2*xlen-1:xlen];
    // a target in the upper half skips the lower instruction.
    pair.ready0 = head_valid & ~head_line.pc[2];
    pair.ready1 = head_valid;
  end

endmodule

`default_nettype wire

//--- source/fetch_control.sv
`default_nettype none

module fetch_control import fetch_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        clear,
  input  redirect_t   redirect,
  input  logic        full,
  input  imem_rsp_t   imem_rsp,
  output imem_req_t   imem_req,
  output logic        line_push,
  output fetch_line_t line
);

  fetch_state_t    state;
  fetch_state_t    state_next;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_next;
  logic [xlen-1:0] req_addr;
  logic [xlen-1:0] req_pc;     // address of the request in flight.
  logic            can_issue;
  logic            issue;
  logic            fence_pend; // an invalidate goes out with the next request.
  logic            spec_pend;

  assign req_addr = {pc[xlen-1:2], 2'b00};

  // ~~~~~~~~~~~~~~~~~~~~
  // request decision
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (state)
      idle:    can_issue = ~clear;
      busy:    can_issue = imem_rsp.ready;
      ctrl:    can_issue = imem_rsp.ready; // the cancelled response ends here.
      inv:     can_issue = imem_rsp.ready;
      default: can_issue = 1'b0;
    endcase
  end

  // a redirect in this cycle moves the pc first, the request follows next cycle.
  // no request leaves while reset is held.
  assign issue = can_issue & ~full & ~redirect.spec & reset;

  always_comb begin
    state_next = state;
    if (issue) begin
      state_next = busy;
    end else if (can_issue || state == idle) begin
      // nothing is outstanding, so wait in idle for room or a settled pc.
      state_next = idle;
    end else if (redirect.spec) begin
      state_next = redirect.fence ? inv : ctrl;
    end
  end

  always_comb begin
    pc_next = pc;
    if (redirect.spec) begin
      pc_next = redirect.target;
    end else if (issue) begin
      pc_next = {pc[xlen-1:3], 3'b000} + xlen'(line_bytes);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // registers
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= idle;
      pc <= reset_pc;
      fence_pend <= 1'b0;
      spec_pend <= 1'b0;
    end else begin
      state <= state_next;
      pc <= pc_next;
      if (redirect.spec) begin
        spec_pend <= 1'b1;
        fence_pend <= fence_pend | redirect.fence;
      end else if (issue) begin
        spec_pend <= 1'b0;
        fence_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      req_pc <= req_addr;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // outputs
  // ~~~~~~~~~~~~~~~~~~~~

  assign imem_req.valid = issue;
  assign imem_req.fence = issue & fence_pend;
  assign imem_req.spec = issue & spec_pend;
  assign imem_req.addr = req_addr;

  // responses seen in ctrl or inv belong to a cancelled request.
  assign line_push = (state == busy) & imem_rsp.ready;
  assign line.pc = req_pc;
  assign line.rdata = imem_rsp.rdata;

endmodule

`default_nettype wire

//--- source/fetch_redirect.sv
`default_nettype none

module fetch_redirect import fetch_pkg::*; (
  input  redirect_in_t redirect_in,
  output redirect_t    redirect
);

  // ~~~~~~~~~~~~~~~~~~~~
  // priority decode
  // ~~~~~~~~~~~~~~~~~~~~
  // highest first: trap, mret, misprediction, fence, predicted taken.
  // with no source active the result is all zero and the pc advances.

  always_comb begin
    redirect = '0;

    if (redirect_in.trap) begin
      redirect.spec = 1'b1;
      redirect.fence = 1'b0;
      redirect.target = redirect_in.mtvec;
    end else if (redirect_in.mret) begin
      redirect.spec = 1'b1;
      redirect.fence = 1'b0;
      redirect.target = redirect_in.mepc;
    end else if (redirect_in.miss) begin
      // the corrected address from execute.
      redirect.spec = 1'b1;
      redirect.fence = 1'b0;
      redirect.target = redirect_in.miss_addr;
    end else if (redirect_in.fence) begin
      redirect.spec = 1'b1;
      redirect.fence = 1'b1; // the memory must invalidate before refetch.
      redirect.target = redirect_in.fence_npc;
    end else if (redirect_in.taken) begin
      redirect.spec = 1'b1;
      redirect.fence = 1'b0;
      redirect.target = redirect_in.taddr;
    end
  end

endmodule

`default_nettype wire

//--- source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // sizes and constants
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int xlen = 32;
  localparam int line_bytes = 8; // one line is two instructions.
  localparam int instr_bytes = 4;
  localparam int buffer_depth = 4;
  localparam int buffer_ptr_bits = $clog2(buffer_depth);
  // one request may still be in flight when full rises, so leave room for its line.
  localparam int full_level = buffer_depth - 1;
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  typedef enum logic [1:0] {
    idle = 2'd0,
    busy = 2'd1,
    ctrl = 2'd2,
    inv  = 2'd3
  } fetch_state_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // interface structs
  // ~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic            trap;
    logic [xlen-1:0] mtvec;
    logic            mret;
    logic [xlen-1:0] mepc;
    logic            miss;
    logic [xlen-1:0] miss_addr;
    logic            fence;
    logic [xlen-1:0] fence_npc;
    logic            taken;
    logic [xlen-1:0] taddr;
  } redirect_in_t;

  typedef struct packed {
    logic            spec;   // set for any redirect.
    logic            fence;  // set only when the fence source wins.
    logic [xlen-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic            valid;
    logic            fence;
    logic            spec;
    logic [xlen-1:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic                ready;
    logic [2*xlen-1:0]   rdata;
  } imem_rsp_t;

  typedef struct packed {
    logic [xlen-1:0]     pc;
    logic [2*xlen-1:0]   rdata;
  } fetch_line_t;

  typedef struct packed {
    logic [xlen-1:0] pc0;
    logic [xlen-1:0] pc1;
    logic [xlen-1:0] instr0;
    logic [xlen-1:0] instr1;
    logic            ready0;
    logic            ready1;
  } fetch_pair_t;

endpackage

`default_nettype wire
